// ==== cpu_top.f ====
+incdir+.
cpu_pkg.sv
alu.sv
instr_decode.sv
register_file.sv
wb_bus_master.sv
cpu_control.sv
cpu_top.sv
tb_cpu_top.sv

// ==== tb_cpu_model.svh ====
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

// galois lfsr, one step per bit taken
function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
    end
    return v;
endfunction

function automatic logic [31:0] fetch_word(logic [31:0] adr);
    logic [31:0] idx;
    idx = (adr - cpu_pkg::reset_pc) >> 2;
    if (adr < cpu_pkg::reset_pc || idx >= prog.size())
        return '0; // past the program reads as nop
    else
        return prog[idx];
endfunction

// instruction-set model, fills exp_adr/exp_dat and model_mem, returns instruction count
function automatic int run_model();
    logic [31:0] r [32];
    logic [31:0] pc, ins, a, b, res, imm_s, imm_z, adr, next_pc;
    logic [4:0] d;
    cpu_pkg::opcode_e op;
    cpu_pkg::funct_e fn;
    logic wr;
    longint wide;
    int steps;
    for (int i = 0; i < 32; i++)
        r[i] = (i == 29) ? cpu_pkg::reset_sp : '0;
    for (int i = 0; i < 16384; i++)
        model_mem[i] = '0;
    exp_adr.delete();
    exp_dat.delete();
    pc = cpu_pkg::reset_pc;
    steps = 0;
    while (!r[cpu_pkg::ctrl_reg][cpu_pkg::halt_bit] && steps < 5000) begin
        ins = fetch_word(pc);
        op = cpu_pkg::opcode_e'(ins[31:26]);
        fn = cpu_pkg::funct_e'(ins[5:0]);
        a = r[ins[25:21]];
        b = r[ins[20:16]];
        imm_s = {{16{ins[15]}}, ins[15:0]};
        imm_z = {16'h0, ins[15:0]};
        adr = a + imm_s;
        next_pc = pc + 32'd4;
        d = ins[20:16];
        wr = 1'b1;
        res = '0;
        case (op)
            cpu_pkg::op_special: begin
                d = ins[15:11];
                case (fn)
                    cpu_pkg::fn_sll: res = b << ins[10:6];
                    cpu_pkg::fn_srl: res = b >> ins[10:6];
                    cpu_pkg::fn_sra: res = $signed(b) >>> ins[10:6];
                    cpu_pkg::fn_sllv: res = b << a[4:0];
                    cpu_pkg::fn_srlv: res = b >> a[4:0];
                    cpu_pkg::fn_srav: res = $signed(b) >>> a[4:0];
                    cpu_pkg::fn_jr: begin
                        wr = 1'b0;
                        next_pc = a;
                    end
                    cpu_pkg::fn_add: begin
                        wide = longint'($signed(a)) + longint'($signed(b));
                        res = wide[31:0];
                        wr = (wide == longint'($signed(res))); // no write on overflow
                    end
                    cpu_pkg::fn_addu: res = a + b;
                    cpu_pkg::fn_sub: begin
                        wide = longint'($signed(a)) - longint'($signed(b));
                        res = wide[31:0];
                        wr = (wide == longint'($signed(res)));
                    end
                    cpu_pkg::fn_subu: res = a - b;
                    cpu_pkg::fn_and: res = a & b;
                    cpu_pkg::fn_or: res = a | b;
                    cpu_pkg::fn_xor: res = a ^ b;
                    cpu_pkg::fn_nor: res = ~(a | b);
                    cpu_pkg::fn_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    cpu_pkg::fn_sltu: res = (a < b) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            cpu_pkg::op_j: begin
                wr = 1'b0;
                next_pc = {next_pc[31:28], ins[25:0], 2'b00};
            end
            cpu_pkg::op_jal: begin
                d = cpu_pkg::link_reg;
                res = pc + 32'd4;
                next_pc = {next_pc[31:28], ins[25:0], 2'b00};
            end
            cpu_pkg::op_beq: begin
                wr = 1'b0;
                if (a == b)
                    next_pc = next_pc + (imm_s << 2);
            end
            cpu_pkg::op_bne: begin
                wr = 1'b0;
                if (a != b)
                    next_pc = next_pc + (imm_s << 2);
            end
            cpu_pkg::op_addi: begin
                wide = longint'($signed(a)) + longint'($signed(imm_s));
                res = wide[31:0];
                wr = (wide == longint'($signed(res)));
            end
            cpu_pkg::op_addiu: res = adr;
            cpu_pkg::op_slti: res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
            cpu_pkg::op_sltiu: res = (a < imm_s) ? 32'd1 : 32'd0;
            cpu_pkg::op_andi: res = a & imm_z;
            cpu_pkg::op_ori: res = a | imm_z;
            cpu_pkg::op_xori: res = a ^ imm_z;
            cpu_pkg::op_lui: res = {ins[15:0], 16'h0};
            cpu_pkg::op_lw: res = model_mem[adr[15:2]];
            cpu_pkg::op_sw: begin
                wr = 1'b0;
                model_mem[adr[15:2]] = b;
                exp_adr.push_back(adr);
                exp_dat.push_back(b);
            end
            default: wr = 1'b0; // illegal, falls through
        endcase
        if (wr && d != 5'd0)
            r[d] = res;
        pc = next_pc;
        steps++;
    end
    return steps;
endfunction

task automatic check_word(string what, logic [cpu_pkg::xlen-1:0] exp,
                          logic [cpu_pkg::xlen-1:0] act);
    if (act !== exp)
        abort_run($sformatf("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act));
endtask

task automatic check_flag(string what, logic exp, logic act);
    if (act !== exp)
        abort_run($sformatf("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act));
endtask

task automatic check_count(string what, int exp, int act);
    if (act != exp)
        abort_run($sformatf("ERROR %s %s: expected %0d, actual %0d", test_name, what, exp, act));
endtask

`endif

// ==== tb_cpu_top.sv ====
`timescale 1ns/1ps

module tb_cpu_top;
    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic wb_cyc, wb_stb, wb_we, halted;
    logic wb_ack = 1'b0;
    logic [cpu_pkg::xlen-1:0] wb_adr, wb_dat_w;
    logic [cpu_pkg::xlen-1:0] wb_dat_r = '0;

    logic [31:0] lfsr_state = 32'hd8c7e92f;
    logic [31:0] all_words [$]; // every program back to back
    int prog_start [5];
    int prog_len [5];
    string prog_name [5];
    int prog_base;
    int slot;
    logic [31:0] prog [$];
    logic [31:0] dmem [16384];
    logic [31:0] model_mem [16384];
    logic [31:0] exp_adr [$];
    logic [31:0] exp_dat [$];
    int stores_seen = 0;
    int ack_wait = -1;
    int watch_cycles = 0;
    string test_name = "startup";

    `include "tb_cpu_model.svh"

    cpu_top uut (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .halted(halted)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic answer_bus();
        wb_ack <= 1'b1;
        if (wb_we)
            dmem[wb_adr[15:2]] = wb_dat_w;
        else if (wb_adr[31:16] == cpu_pkg::reset_pc[31:16])
            wb_dat_r <= fetch_word(wb_adr);
        else
            wb_dat_r <= dmem[wb_adr[15:2]];
    endtask

    // memory slave with 0 to 3 wait states per cycle
    always @(negedge clk) begin
        if (!rst_n || !wb_cyc || !wb_stb || wb_ack) begin
            wb_ack <= 1'b0;
            ack_wait = -1;
        end else begin
            if (ack_wait < 0)
                ack_wait = int'(take_bits(2));
            if (ack_wait == 0)
                answer_bus();
            ack_wait = ack_wait - 1;
        end
    end

    always @(posedge clk) begin
        if (rst_n && wb_cyc && wb_stb && wb_we && wb_ack) begin
            if (stores_seen >= exp_adr.size()) begin
                abort_run($sformatf("%s: the DUT wrote to %h after the model's last store",
                                    test_name, wb_adr));
            end else begin
                check_word("store address", exp_adr[stores_seen], wb_adr);
                check_word("store data", exp_dat[stores_seen], wb_dat_w);
                stores_seen++;
            end
        end
    end

    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        abort_run($sformatf("timeout: the tests did not finish within %0d clock cycles",
                            watch_cycles));
    end

    function automatic void emit(logic [31:0] word);
        all_words.push_back(word);
    endfunction

    function automatic logic [31:0] here(); // address of the next word
        return cpu_pkg::reset_pc + 32'((all_words.size() - prog_base) * 4);
    endfunction

    function automatic void r_op(cpu_pkg::funct_e fn, logic [4:0] rd, logic [4:0] rs,
                                 logic [4:0] rt, logic [4:0] sh);
        emit({cpu_pkg::op_special, rs, rt, rd, sh, fn});
    endfunction

    function automatic void i_op(cpu_pkg::opcode_e op, logic [4:0] rt, logic [4:0] rs,
                                 logic [15:0] imm);
        emit({op, rs, rt, imm});
    endfunction

    function automatic void j_op(cpu_pkg::opcode_e op, logic [31:0] target);
        emit({op, target[27:2]});
    endfunction

    function automatic void set_reg(logic [4:0] r, logic [31:0] value);
        i_op(cpu_pkg::op_lui, r, 5'd0, value[31:16]);
        i_op(cpu_pkg::op_ori, r, r, value[15:0]);
    endfunction

    function automatic void store(logic [4:0] r); // next free word above the data base
        i_op(cpu_pkg::op_sw, r, 5'd28, 16'(slot * 4));
        slot++;
    endfunction

    function automatic void halt();
        i_op(cpu_pkg::op_ori, cpu_pkg::ctrl_reg, 5'd0, 16'h0008);
    endfunction

    function automatic void begin_prog(int n, string name);
        prog_name[n] = name;
        prog_start[n] = all_words.size();
        prog_base = all_words.size();
        slot = 0;
        i_op(cpu_pkg::op_lui, 5'd28, 5'd0, 16'h1001); // data base
    endfunction

    function automatic void end_prog(int n);
        halt();
        prog_len[n] = all_words.size() - prog_start[n];
    endfunction

    task automatic build_programs();
        cpu_pkg::funct_e rops [16];
        cpu_pkg::opcode_e iops [8];
        logic [15:0] offs;
        rops = '{cpu_pkg::fn_sll, cpu_pkg::fn_srl, cpu_pkg::fn_sra, cpu_pkg::fn_sllv,
                 cpu_pkg::fn_srlv, cpu_pkg::fn_srav, cpu_pkg::fn_add, cpu_pkg::fn_addu,
                 cpu_pkg::fn_sub, cpu_pkg::fn_subu, cpu_pkg::fn_and, cpu_pkg::fn_or,
                 cpu_pkg::fn_xor, cpu_pkg::fn_nor, cpu_pkg::fn_slt, cpu_pkg::fn_sltu};
        iops = '{cpu_pkg::op_addi, cpu_pkg::op_addiu, cpu_pkg::op_slti, cpu_pkg::op_sltiu,
                 cpu_pkg::op_andi, cpu_pkg::op_ori, cpu_pkg::op_xori, cpu_pkg::op_lui};
        begin_prog(0, "alu_reg");
        for (int i = 0; i < 32; i++) begin
            set_reg(5'd8, take_bits(32));
            set_reg(5'd9, take_bits(32));
            r_op(rops[i % 16], 5'd10, 5'd8, 5'd9, 5'(take_bits(5)));
            store(5'd10);
        end
        end_prog(0);
        begin_prog(1, "alu_imm");
        for (int i = 0; i < 24; i++) begin
            set_reg(5'd8, take_bits(32));
            i_op(iops[i % 8], 5'd10, 5'd8, 16'(take_bits(16)));
            store(5'd10);
        end
        set_reg(5'd10, 32'h1234_5678); // marker kept by the overflowing ops
        set_reg(5'd8, 32'h7fff_fff0);
        i_op(cpu_pkg::op_addi, 5'd10, 5'd8, 16'h0100);
        store(5'd10);
        set_reg(5'd9, 32'h7000_0000);
        r_op(cpu_pkg::fn_add, 5'd10, 5'd8, 5'd9, 5'd0);
        store(5'd10);
        set_reg(5'd9, 32'h8000_0000);
        r_op(cpu_pkg::fn_sub, 5'd10, 5'd8, 5'd9, 5'd0);
        store(5'd10);
        r_op(cpu_pkg::fn_addu, 5'd10, 5'd8, 5'd9, 5'd0); // wraps and writes
        store(5'd10);
        end_prog(1);
        begin_prog(2, "load_store");
        for (int i = 0; i < 8; i++) begin
            offs = 16'h0400 + 16'(take_bits(8) << 2);
            set_reg(5'd8, take_bits(32));
            i_op(cpu_pkg::op_sw, 5'd8, 5'd28, offs);
            i_op(cpu_pkg::op_lw, 5'd11, 5'd28, offs);
            store(5'd11);
        end
        end_prog(2);
        begin_prog(3, "control_flow");
        set_reg(5'd8, 32'd5);
        set_reg(5'd9, 32'd5);
        set_reg(5'd12, 32'd7);
        i_op(cpu_pkg::op_beq, 5'd9, 5'd8, 16'd1); // taken
        store(5'd8);
        store(5'd9);
        i_op(cpu_pkg::op_bne, 5'd9, 5'd8, 16'd1); // not taken
        store(5'd12);
        i_op(cpu_pkg::op_beq, 5'd12, 5'd8, 16'd1); // not taken
        store(5'd12);
        i_op(cpu_pkg::op_bne, 5'd12, 5'd8, 16'd1); // taken
        store(5'd8);
        j_op(cpu_pkg::op_j, here() + 32'd8);
        store(5'd8);
        set_reg(5'd13, 32'd3);
        store(5'd13);                                 // loop body runs 3 times
        i_op(cpu_pkg::op_addiu, 5'd13, 5'd13, 16'hffff);
        i_op(cpu_pkg::op_bne, 5'd0, 5'd13, 16'hfffd);
        j_op(cpu_pkg::op_jal, here() + 32'd12);
        store(5'd12);
        halt();
        store(5'd31);                                 // subroutine stores the link
        r_op(cpu_pkg::fn_jr, 5'd0, 5'd31, 5'd0, 5'd0);
        end_prog(3);
        begin_prog(4, "halt");
        set_reg(5'd8, take_bits(32));
        store(5'd8);
        halt();
        store(5'd8);
        end_prog(4);
    endtask

    task automatic load_prog(int t);
        prog.delete();
        for (int i = 0; i < prog_len[t]; i++)
            prog.push_back(all_words[prog_start[t] + i]);
    endtask

    task automatic run_test(int t);
        int steps;
        test_name = prog_name[t];
        load_prog(t);
        steps = run_model();
        for (int i = 0; i < 16384; i++)
            dmem[i] = '0;
        @(negedge clk);
        rst_n = 1'b0;
        stores_seen = 0;
        repeat (5) @(negedge clk);
        check_flag("wb_cyc in reset", 1'b0, wb_cyc);
        check_flag("wb_stb in reset", 1'b0, wb_stb);
        check_flag("wb_we in reset", 1'b0, wb_we);
        check_flag("halted in reset", 1'b0, halted);
        rst_n = 1'b1;
        while (!wb_cyc)
            @(negedge clk);
        check_word("first fetch address", cpu_pkg::reset_pc, wb_adr);
        while (!halted)
            @(negedge clk);
        repeat (50) begin
            @(negedge clk);
            check_flag("wb_cyc after halt", 1'b0, wb_cyc);
            check_flag("halted held", 1'b1, halted);
        end
        check_count("number of stores", exp_adr.size(), stores_seen);
        $display("%s: %0d instructions, %0d stores", test_name, steps, stores_seen);
    endtask

    initial begin
        int total;
        build_programs();
        total = 0;
        for (int t = 0; t < 5; t++) begin
            load_prog(t);
            total += run_model();
        end
        watch_cycles = total * 40 * 4 + 5 * 200; // plus reset and halt checks
        for (int t = 0; t < 5; t++)
            run_test(t);
        $display("sim passed");
        $finish;
    end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [cpu_pkg::xlen-1:0] wb_adr,
    output logic [cpu_pkg::xlen-1:0] wb_dat_w,
    input  logic [cpu_pkg::xlen-1:0] wb_dat_r,
    input  logic                     wb_ack,
    output logic                     halted
);
    logic [cpu_pkg::xlen-1:0] instr, rs_data, rt_data, alu_result;
    logic [cpu_pkg::xlen-1:0] rf_wdata, bus_adr, bus_wdata, bus_rdata;
    logic [cpu_pkg::reg_addr_w-1:0] rs, rt, dest, rf_waddr;
    cpu_pkg::alu_op_e alu_op;
    cpu_pkg::src_b_e src_b;
    cpu_pkg::instr_class_e instr_class;
    logic use_shamt, trap_overflow, alu_overflow, ctrl_halt;
    logic rf_we, bus_req, bus_we, bus_done;

    // second operand select
    wire [cpu_pkg::xlen-1:0] alu_b =
        (src_b == cpu_pkg::src_imm_s) ? {{16{instr[15]}}, instr[15:0]} :
        (src_b == cpu_pkg::src_imm_z) ? {16'h0, instr[15:0]} : rt_data;

    cpu_control u_control (
        .clk(clk), .rst_n(rst_n), .instr(instr), .instr_class(instr_class), .dest(dest),
        .rs_data(rs_data), .rt_data(rt_data), .alu_result(alu_result),
        .alu_overflow(alu_overflow && trap_overflow), .ctrl_halt(ctrl_halt),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .bus_req(bus_req), .bus_we(bus_we), .bus_adr(bus_adr), .bus_wdata(bus_wdata),
        .bus_rdata(bus_rdata), .bus_done(bus_done), .halted(halted)
    );

    instr_decode u_decode (
        .instr(instr), .rs(rs), .rt(rt), .dest(dest), .alu_op(alu_op), .src_b(src_b),
        .use_shamt(use_shamt), .trap_overflow(trap_overflow), .instr_class(instr_class)
    );

    register_file u_regs (
        .clk(clk), .rst_n(rst_n), .raddr_a(rs), .raddr_b(rt),
        .rdata_a(rs_data), .rdata_b(rt_data),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata), .ctrl_halt(ctrl_halt)
    );

    alu u_alu (
        .op(alu_op), .a(rs_data), .b(alu_b), .shamt(instr[10:6]), .use_shamt(use_shamt),
        .result(alu_result), .overflow(alu_overflow)
    );

    wb_bus_master u_bus (
        .clk(clk), .rst_n(rst_n), .req(bus_req), .we(bus_we), .adr(bus_adr),
        .wdata(bus_wdata), .rdata(bus_rdata), .done(bus_done),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

endmodule

// ==== cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control (
    input  logic                           clk,
    input  logic                           rst_n,
    output logic [cpu_pkg::xlen-1:0]       instr,
    input  cpu_pkg::instr_class_e          instr_class,
    input  logic [cpu_pkg::reg_addr_w-1:0] dest,
    input  logic [cpu_pkg::xlen-1:0]       rs_data,
    input  logic [cpu_pkg::xlen-1:0]       rt_data,
    input  logic [cpu_pkg::xlen-1:0]       alu_result,
    input  logic                           alu_overflow,
    input  logic                           ctrl_halt,
    output logic                           rf_we,
    output logic [cpu_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [cpu_pkg::xlen-1:0]       rf_wdata,
    output logic                           bus_req,
    output logic                           bus_we,
    output logic [cpu_pkg::xlen-1:0]       bus_adr,
    output logic [cpu_pkg::xlen-1:0]       bus_wdata,
    input  logic [cpu_pkg::xlen-1:0]       bus_rdata,
    input  logic                           bus_done,
    output logic                           halted
);
    cpu_pkg::state_e state;
    cpu_pkg::opcode_e opcode;
    logic [cpu_pkg::xlen-1:0] pc, pc_plus4, br_target, j_target;
    logic [cpu_pkg::xlen-1:0] result_q; // alu result then load data
    logic ovf_q;
    logic busy;                         // bus cycle open
    logic take_branch, writes_reg;

    assign opcode = cpu_pkg::opcode_e'(instr[31:26]);
    assign pc_plus4 = pc + 32'd4;
    assign br_target = pc_plus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
    assign j_target = {pc_plus4[31:28], instr[25:0], 2'b00};
    assign take_branch = (opcode == cpu_pkg::op_beq) ? result_q[0] : !result_q[0];

    assign bus_req = !busy && ((state == cpu_pkg::st_fetch && !ctrl_halt)
                               || state == cpu_pkg::st_mem);
    assign bus_we = (state == cpu_pkg::st_mem) && (instr_class == cpu_pkg::cls_store);
    assign bus_adr = (state == cpu_pkg::st_mem) ? result_q : pc;
    assign bus_wdata = rt_data;

    always_comb begin
        case (instr_class)
            cpu_pkg::cls_alu_reg, cpu_pkg::cls_alu_imm: writes_reg = !ovf_q;
            cpu_pkg::cls_load: writes_reg = 1'b1;
            cpu_pkg::cls_jump: writes_reg = (opcode == cpu_pkg::op_jal);
            default: writes_reg = 1'b0;
        endcase
    end

    assign rf_we = (state == cpu_pkg::st_writeback) && writes_reg;
    assign rf_waddr = dest;
    assign rf_wdata = (instr_class == cpu_pkg::cls_jump) ? pc_plus4 : result_q; // jal link

    assign halted = (state == cpu_pkg::st_halted);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= cpu_pkg::st_fetch;
            pc <= cpu_pkg::reset_pc;
            busy <= 1'b0;
        end else begin
            if (bus_req)
                busy <= 1'b1;
            else if (bus_done)
                busy <= 1'b0;
            case (state)
                cpu_pkg::st_fetch: begin
                    if (bus_done)
                        state <= cpu_pkg::st_decode;
                    else if (!busy && ctrl_halt)
                        state <= cpu_pkg::st_halted;
                end
                cpu_pkg::st_decode: state <= cpu_pkg::st_execute;
                cpu_pkg::st_execute: begin
                    if (instr_class == cpu_pkg::cls_load || instr_class == cpu_pkg::cls_store)
                        state <= cpu_pkg::st_mem;
                    else
                        state <= cpu_pkg::st_writeback;
                end
                cpu_pkg::st_mem: begin
                    if (bus_done)
                        state <= cpu_pkg::st_writeback;
                end
                cpu_pkg::st_writeback: begin
                    state <= cpu_pkg::st_fetch;
                    case (instr_class)
                        cpu_pkg::cls_branch: pc <= take_branch ? br_target : pc_plus4;
                        cpu_pkg::cls_jump: pc <= j_target;
                        cpu_pkg::cls_jump_reg: pc <= rs_data;
                        default: pc <= pc_plus4;
                    endcase
                end
                default: state <= cpu_pkg::st_halted; // held until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::st_fetch && bus_done)
            instr <= bus_rdata;
        if (state == cpu_pkg::st_execute) begin
            result_q <= alu_result;
            ovf_q <= alu_overflow;
        end
        if (state == cpu_pkg::st_mem && bus_done)
            result_q <= bus_rdata;
    end

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted);

    // data access only for lw and sw
    a_req_state: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req |-> state == cpu_pkg::st_fetch
                    || (state == cpu_pkg::st_mem && (instr_class == cpu_pkg::cls_load
                                                     || instr_class == cpu_pkg::cls_store)));

endmodule

// ==== wb_bus_master.sv ====
`timescale 1ns/1ps

module wb_bus_master (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req,
    input  logic                     we,
    input  logic [cpu_pkg::xlen-1:0] adr,
    input  logic [cpu_pkg::xlen-1:0] wdata,
    output logic [cpu_pkg::xlen-1:0] rdata,
    output logic                     done,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [cpu_pkg::xlen-1:0] wb_adr,
    output logic [cpu_pkg::xlen-1:0] wb_dat_w,
    input  logic [cpu_pkg::xlen-1:0] wb_dat_r,
    input  logic                     wb_ack
);
    logic start, finish;

    assign start = req && !wb_cyc;
    assign finish = wb_cyc && wb_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= finish; // one pulse per cycle
            if (finish) begin
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
                wb_we <= 1'b0;
            end else if (start) begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
                wb_we <= we;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr <= adr;
            wb_dat_w <= wdata;
        end
        if (finish)
            rdata <= wb_dat_r;
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w));

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr_a,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr_b,
    output logic [cpu_pkg::xlen-1:0]       rdata_a,
    output logic [cpu_pkg::xlen-1:0]       rdata_b,
    input  logic                           we,
    input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
    input  logic [cpu_pkg::xlen-1:0]       wdata,
    output logic                           ctrl_halt
);
    logic [cpu_pkg::xlen-1:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= (i == 29) ? cpu_pkg::reset_sp : '0; // sp preset
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];
    assign ctrl_halt = regs[cpu_pkg::ctrl_reg][cpu_pkg::halt_bit];

    a_zero_reg: assert property (@(posedge clk) disable iff (!rst_n)
        (raddr_a == '0 |-> rdata_a == '0) and (raddr_b == '0 |-> rdata_b == '0));

endmodule

// ==== instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
    input  logic [cpu_pkg::xlen-1:0]       instr,
    output logic [cpu_pkg::reg_addr_w-1:0] rs,
    output logic [cpu_pkg::reg_addr_w-1:0] rt,
    output logic [cpu_pkg::reg_addr_w-1:0] dest,
    output cpu_pkg::alu_op_e               alu_op,
    output cpu_pkg::src_b_e                src_b,
    output logic                           use_shamt,
    output logic                           trap_overflow,
    output cpu_pkg::instr_class_e          instr_class
);
    cpu_pkg::opcode_e opcode;
    cpu_pkg::funct_e funct;
    logic special;

    assign opcode = cpu_pkg::opcode_e'(instr[31:26]);
    assign funct = cpu_pkg::funct_e'(instr[5:0]);
    assign special = (opcode == cpu_pkg::op_special);
    assign rs = instr[25:21];
    assign rt = instr[20:16];

    assign use_shamt = special && (funct == cpu_pkg::fn_sll || funct == cpu_pkg::fn_srl
                                   || funct == cpu_pkg::fn_sra);
    assign trap_overflow = (special && (funct == cpu_pkg::fn_add || funct == cpu_pkg::fn_sub))
                           || opcode == cpu_pkg::op_addi;

    always_comb begin
        alu_op = cpu_pkg::alu_add; // addu, addiu, lw, sw
        if (special) begin
            case (funct)
                cpu_pkg::fn_sll, cpu_pkg::fn_sllv: alu_op = cpu_pkg::alu_sll;
                cpu_pkg::fn_srl, cpu_pkg::fn_srlv: alu_op = cpu_pkg::alu_srl;
                cpu_pkg::fn_sra, cpu_pkg::fn_srav: alu_op = cpu_pkg::alu_sra;
                cpu_pkg::fn_sub, cpu_pkg::fn_subu: alu_op = cpu_pkg::alu_sub;
                cpu_pkg::fn_and: alu_op = cpu_pkg::alu_and;
                cpu_pkg::fn_or: alu_op = cpu_pkg::alu_or;
                cpu_pkg::fn_xor: alu_op = cpu_pkg::alu_xor;
                cpu_pkg::fn_nor: alu_op = cpu_pkg::alu_nor;
                cpu_pkg::fn_slt: alu_op = cpu_pkg::alu_slt;
                cpu_pkg::fn_sltu: alu_op = cpu_pkg::alu_sltu;
                default: alu_op = cpu_pkg::alu_add;
            endcase
        end else begin
            case (opcode)
                cpu_pkg::op_beq, cpu_pkg::op_bne: alu_op = cpu_pkg::alu_eq;
                cpu_pkg::op_slti: alu_op = cpu_pkg::alu_slt;
                cpu_pkg::op_sltiu: alu_op = cpu_pkg::alu_sltu;
                cpu_pkg::op_andi: alu_op = cpu_pkg::alu_and;
                cpu_pkg::op_ori: alu_op = cpu_pkg::alu_or;
                cpu_pkg::op_xori: alu_op = cpu_pkg::alu_xor;
                cpu_pkg::op_lui: alu_op = cpu_pkg::alu_lui;
                default: alu_op = cpu_pkg::alu_add;
            endcase
        end
    end

    always_comb begin
        instr_class = cpu_pkg::cls_alu_imm;
        src_b = cpu_pkg::src_imm_s;
        dest = rt;
        case (opcode)
            cpu_pkg::op_special: begin
                dest = instr[15:11];
                src_b = cpu_pkg::src_rt;
                case (funct)
                    cpu_pkg::fn_jr: instr_class = cpu_pkg::cls_jump_reg;
                    cpu_pkg::fn_sll, cpu_pkg::fn_srl, cpu_pkg::fn_sra, cpu_pkg::fn_sllv,
                    cpu_pkg::fn_srlv, cpu_pkg::fn_srav, cpu_pkg::fn_add, cpu_pkg::fn_addu,
                    cpu_pkg::fn_sub, cpu_pkg::fn_subu, cpu_pkg::fn_and, cpu_pkg::fn_or,
                    cpu_pkg::fn_xor, cpu_pkg::fn_nor, cpu_pkg::fn_slt, cpu_pkg::fn_sltu:
                        instr_class = cpu_pkg::cls_alu_reg;
                    default: instr_class = cpu_pkg::cls_illegal;
                endcase
            end
            cpu_pkg::op_j: instr_class = cpu_pkg::cls_jump;
            cpu_pkg::op_jal: begin
                instr_class = cpu_pkg::cls_jump;
                dest = cpu_pkg::link_reg;
            end
            cpu_pkg::op_beq, cpu_pkg::op_bne: begin
                instr_class = cpu_pkg::cls_branch;
                src_b = cpu_pkg::src_rt;
            end
            cpu_pkg::op_addi, cpu_pkg::op_addiu, cpu_pkg::op_slti, cpu_pkg::op_sltiu:
                src_b = cpu_pkg::src_imm_s;
            cpu_pkg::op_andi, cpu_pkg::op_ori, cpu_pkg::op_xori, cpu_pkg::op_lui:
                src_b = cpu_pkg::src_imm_z;
            cpu_pkg::op_lw: instr_class = cpu_pkg::cls_load;
            cpu_pkg::op_sw: instr_class = cpu_pkg::cls_store;
            default: instr_class = cpu_pkg::cls_illegal;
        endcase
    end

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_e         op,
    input  logic [cpu_pkg::xlen-1:0] a,
    input  logic [cpu_pkg::xlen-1:0] b,
    input  logic [4:0]               shamt,
    input  logic                     use_shamt,
    output logic [cpu_pkg::xlen-1:0] result,
    output logic                     overflow
);
    logic [cpu_pkg::xlen-1:0] sum, diff;
    logic [4:0] count;

    assign sum = a + b;
    assign diff = a - b;
    assign count = use_shamt ? shamt : a[4:0]; // sllv etc. take rs

    always_comb begin
        case (op)
            cpu_pkg::alu_add: result = sum;
            cpu_pkg::alu_sub: result = diff;
            cpu_pkg::alu_and: result = a & b;
            cpu_pkg::alu_or: result = a | b;
            cpu_pkg::alu_xor: result = a ^ b;
            cpu_pkg::alu_nor: result = ~(a | b);
            cpu_pkg::alu_slt: result = {31'd0, $signed(a) < $signed(b)};
            cpu_pkg::alu_sltu: result = {31'd0, a < b};
            cpu_pkg::alu_sll: result = b << count;
            cpu_pkg::alu_srl: result = b >> count;
            cpu_pkg::alu_sra: result = $signed(b) >>> count;
            cpu_pkg::alu_eq: result = {31'd0, a == b};
            cpu_pkg::alu_lui: result = {b[15:0], 16'h0};
            default: result = '0;
        endcase
    end

    // sign of result disagrees with like-signed operands
    always_comb begin
        case (op)
            cpu_pkg::alu_add: overflow = (a[31] == b[31]) && (sum[31] != a[31]);
            cpu_pkg::alu_sub: overflow = (a[31] != b[31]) && (diff[31] != a[31]);
            default: overflow = 1'b0;
        endcase
    end

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h0040_0000;
    localparam logic [xlen-1:0] reset_sp = 32'h7fff_effc;

    localparam logic [reg_addr_w-1:0] ctrl_reg = 5'd27;
    localparam int halt_bit = 3;
    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addi    = 6'h08,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_sllv = 6'h04,
        fn_srlv = 6'h06,
        fn_srav = 6'h07,
        fn_jr   = 6'h08,
        fn_add  = 6'h20,
        fn_addu = 6'h21,
        fn_sub  = 6'h22,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_slt,
        alu_sltu, alu_sll, alu_srl, alu_sra, alu_eq, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {src_rt, src_imm_s, src_imm_z} src_b_e;

    typedef enum logic [2:0] {
        cls_alu_reg, cls_alu_imm, cls_load, cls_store,
        cls_branch, cls_jump, cls_jump_reg, cls_illegal
    } instr_class_e;

    typedef enum logic [2:0] {
        st_fetch, st_decode, st_execute, st_mem, st_writeback, st_halted
    } state_e;

endpackage
